/* src/lc3b_types.sv */
package lc3b_types;

// ~~~~~~~~~~~~~~~~~~~~
// Machine widths
// ~~~~~~~~~~~~~~~~~~~~

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;                // n, z, p

localparam int reg_count = 8;
localparam lc3b_nzp cc_reset = 3'b010;       // Z set out of reset

// ~~~~~~~~~~~~~~~~~~~~
// Opcodes
// ~~~~~~~~~~~~~~~~~~~~

typedef enum logic [3:0]
{
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,                        // Also RET
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

// Destination tag carried by a later pipeline stage
typedef struct packed
{
	lc3b_reg drid;
	logic ld_reg;
	logic ld_cc;
} lc3b_wr_tag;

endpackage : lc3b_types

/* src/lc3b_ctrl_pkg.sv */
package lc3b_ctrl_pkg;

import lc3b_types::*;

// ~~~~~~~~~~~~~~~~~~~~
// ALU operations
// ~~~~~~~~~~~~~~~~~~~~

typedef enum logic [2:0]
{
	alu_add,
	alu_and,
	alu_not,
	alu_pass,
	alu_sll,
	alu_srl,
	alu_sra
} lc3b_aluop;

// ~~~~~~~~~~~~~~~~~~~~
// Control word
// ~~~~~~~~~~~~~~~~~~~~

typedef struct packed
{
	lc3b_opcode opcode;
	lc3b_aluop aluop;
	logic sr1_needed;
	logic sr2_needed;
	logic regfilemux_sel;                     // 1: ir[2:0], 0: ir[11:9]
	logic destmux_sel;                        // 1: R7
	logic load_regfile;
	logic load_cc;
	logic is_branch;
	logic mem_read;
	logic mem_write;
	logic imm_mode;
} lc3b_control_word;

// Stall requests from downstream stages and the icache
typedef struct packed
{
	logic execute_br_stall;
	logic execute_indirect_stall;
	logic mem_stall;
	logic mem_br_stall;
	logic icache_stall_int;
} lc3b_stall_in;

endpackage : lc3b_ctrl_pkg

/* src/control_rom.sv */
module control_rom
	import lc3b_types::*, lc3b_ctrl_pkg::*;
(
	input lc3b_word ir,
	output lc3b_control_word cw
);

lc3b_opcode opcode;

assign opcode = lc3b_opcode'(ir[15:12]);

always_comb
begin
	cw = '0;
	cw.opcode = opcode;
	cw.aluop = alu_add;                       // Address arithmetic by default
	case (opcode)
		op_br:
			cw.is_branch = 1'b1;
		op_add, op_and:
		begin
			cw.aluop = (opcode == op_and) ? alu_and : alu_add;
			cw.sr1_needed = 1'b1;
			cw.imm_mode = ir[5];
			cw.sr2_needed = ~ir[5];           // Register mode only
			cw.regfilemux_sel = ~ir[5];
			cw.load_regfile = 1'b1;
			cw.load_cc = 1'b1;
		end
		op_ldb, op_ldr, op_ldi:
		begin
			cw.sr1_needed = 1'b1;
			cw.mem_read = 1'b1;
			cw.load_regfile = 1'b1;
			cw.load_cc = 1'b1;
		end
		op_stb, op_str, op_sti:
		begin
			cw.sr1_needed = 1'b1;
			cw.sr2_needed = 1'b1;             // Store data from ir[11:9]
			cw.mem_read = (opcode == op_sti);  // Pointer fetch first
			cw.mem_write = 1'b1;
		end
		op_jsr:
		begin
			cw.sr1_needed = ~ir[11];          // JSRR base register
			cw.destmux_sel = 1'b1;
			cw.load_regfile = 1'b1;
			cw.is_branch = 1'b1;
		end
		op_not:
		begin
			cw.aluop = alu_not;
			cw.sr1_needed = 1'b1;
			cw.load_regfile = 1'b1;
			cw.load_cc = 1'b1;
		end
		op_jmp:
		begin
			cw.aluop = alu_pass;
			cw.sr1_needed = 1'b1;
			cw.is_branch = 1'b1;
		end
		op_shf:
		begin
			// Direction from bit 4, arithmetic from bit 5
			if (!ir[4])
				cw.aluop = alu_sll;
			else
				cw.aluop = ir[5] ? alu_sra : alu_srl;
			cw.sr1_needed = 1'b1;
			cw.load_regfile = 1'b1;
			cw.load_cc = 1'b1;
		end
		op_lea:
		begin
			cw.load_regfile = 1'b1;
			cw.load_cc = 1'b1;
		end
		op_trap:
		begin
			cw.aluop = alu_pass;
			cw.destmux_sel = 1'b1;
			cw.load_regfile = 1'b1;
			cw.is_branch = 1'b1;
			cw.mem_read = 1'b1;               // Vector table read
		end
		op_rti:
			cw.aluop = alu_pass;              // Treated as no-op
	endcase
end

endmodule : control_rom

/* src/operand_fetch.sv */
module operand_fetch
	import lc3b_types::*, lc3b_ctrl_pkg::*;
(
	input clk,
	input rst,
	input lc3b_word ir,
	input lc3b_control_word cw,

	input lc3b_word reg_data,
	input lc3b_reg dest_reg,
	input lc3b_nzp cc_data,
	input lc3b_wr_tag wb_tag,

	output lc3b_word sr1,
	output lc3b_word sr2,
	output lc3b_reg sr2_id,
	output lc3b_reg dr,
	output lc3b_nzp cc_out
);

lc3b_word regs [reg_count];
lc3b_nzp cc;

// ~~~~~~~~~~~~~~~~~~~~
// Register file and cc
// ~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk)
begin
	if (rst)
	begin
		for (int i = 0; i < reg_count; i++)
			regs[i] <= '0;
		cc <= cc_reset;
	end
	else
	begin
		if (wb_tag.ld_reg)
			regs[dest_reg] <= reg_data;   // Visible from next cycle
		if (wb_tag.ld_cc)
			cc <= cc_data;
	end
end

// ~~~~~~~~~~~~~~~~~~~~
// Source and dest select
// ~~~~~~~~~~~~~~~~~~~~

assign sr2_id = cw.regfilemux_sel ? ir[2:0] : ir[11:9];
assign dr = cw.destmux_sel ? 3'b111 : ir[11:9];   // R7 for link

assign sr1 = regs[ir[8:6]];
assign sr2 = regs[sr2_id];
assign cc_out = cc;

cc_write_onehot: assert property (@(posedge clk) disable iff (rst)
	wb_tag.ld_cc |-> $onehot0(cc_data))
	else $error("cc write with more than one flag set");

// Hazard check relies on the tag naming the written register
write_tag_match: assert property (@(posedge clk) disable iff (rst)
	wb_tag.ld_reg |-> dest_reg == wb_tag.drid)
	else $error("register write to a register other than the wb_tag destination");

endmodule : operand_fetch

/* src/hazard_unit.sv */
module hazard_unit
	import lc3b_types::*, lc3b_ctrl_pkg::*;
(
	input valid_in,
	input lc3b_reg sr1_id,
	input lc3b_reg sr2_id,
	input lc3b_control_word cw,

	input lc3b_wr_tag ex_tag,
	input lc3b_wr_tag mem_tag,
	input lc3b_wr_tag wb_tag,

	input lc3b_stall_in stall_in,

	output logic dep_stall,
	output logic decode_br_stall,
	output logic valid,
	output logic load_ex
);

lc3b_wr_tag [2:0] tags;
logic sr1_hit;
logic sr2_hit;
logic cc_hit;

assign tags = {ex_tag, mem_tag, wb_tag};

// ~~~~~~~~~~~~~~~~~~~~
// Dependence check
// ~~~~~~~~~~~~~~~~~~~~

always_comb
begin
	sr1_hit = 1'b0;
	sr2_hit = 1'b0;
	cc_hit = 1'b0;
	for (int i = 0; i < 3; i++)
	begin
		if (tags[i].ld_reg && tags[i].drid == sr1_id)
			sr1_hit = 1'b1;
		if (tags[i].ld_reg && tags[i].drid == sr2_id)
			sr2_hit = 1'b1;
		if (tags[i].ld_cc)
			cc_hit = 1'b1;                    // BR reads nzp
	end
end

assign dep_stall = valid_in &&
	((cw.sr1_needed && sr1_hit) ||
	(cw.sr2_needed && sr2_hit) ||
	(cw.opcode == op_br && cc_hit));

// ~~~~~~~~~~~~~~~~~~~~
// Stall combination
// ~~~~~~~~~~~~~~~~~~~~

assign valid = valid_in && !dep_stall &&
	!stall_in.execute_br_stall && !stall_in.mem_br_stall;

assign decode_br_stall = valid && cw.is_branch;   // Hold fetch until resolved

assign load_ex = !(stall_in.mem_stall || stall_in.execute_indirect_stall ||
	stall_in.icache_stall_int);

endmodule : hazard_unit

/* src/decode_stage.sv */
module decode_stage
	import lc3b_types::*, lc3b_ctrl_pkg::*;
(
	input clk,
	input rst,
	input lc3b_word npc_in,
	input lc3b_word ir_in,
	input valid_in,

	// Writeback
	input lc3b_word reg_data,
	input lc3b_reg dest_reg,
	input lc3b_nzp cc_data,

	// Later stage destinations
	input lc3b_wr_tag ex_tag,
	input lc3b_wr_tag mem_tag,
	input lc3b_wr_tag wb_tag,

	input lc3b_stall_in stall_in,

	output lc3b_word npc,
	output lc3b_word ir,
	output lc3b_control_word cw,
	output lc3b_word sr1,
	output lc3b_word sr2,
	output lc3b_nzp cc_out,
	output lc3b_reg dr,
	output logic valid,
	output logic load_ex,
	output logic dep_stall,
	output logic decode_br_stall
);

lc3b_reg sr2_id;

assign npc = npc_in;
assign ir = ir_in;

// ~~~~~~~~~~~~~~~~~~~~
// Decode blocks
// ~~~~~~~~~~~~~~~~~~~~

control_rom control_store
(
	.ir(ir_in),
	.cw
);

operand_fetch operands
(
	.clk,
	.rst,
	.ir(ir_in),
	.cw,
	.reg_data,
	.dest_reg,
	.cc_data,
	.wb_tag,
	.sr1,
	.sr2,
	.sr2_id,
	.dr,
	.cc_out
);

hazard_unit hazards
(
	.valid_in,
	.sr1_id(ir_in[8:6]),                      // Source one is fixed
	.sr2_id,
	.cw,
	.ex_tag,
	.mem_tag,
	.wb_tag,
	.stall_in,
	.dep_stall,
	.decode_br_stall,
	.valid,
	.load_ex
);

endmodule : decode_stage

/* testbench/tb_decode_stage.sv */
module tb_decode_stage
	import lc3b_types::*, lc3b_ctrl_pkg::*;
();

localparam int edge_timeout = 100;           // Poll steps per clock edge
localparam int random_cycles = 2000;

logic clk;
logic rst;
lc3b_word npc_in;
lc3b_word ir_in;
logic valid_in;
lc3b_word reg_data;
lc3b_reg dest_reg;
lc3b_nzp cc_data;
lc3b_wr_tag ex_tag;
lc3b_wr_tag mem_tag;
lc3b_wr_tag wb_tag;
lc3b_stall_in stall_in;

lc3b_word npc;
lc3b_word ir;
lc3b_control_word cw;
lc3b_word sr1;
lc3b_word sr2;
lc3b_nzp cc_out;
lc3b_reg dr;
logic valid;
logic load_ex;
logic dep_stall;
logic decode_br_stall;

lc3b_word model_regs [reg_count];
lc3b_nzp model_cc;

decode_stage DUT
(
	.clk,
	.rst,
	.npc_in,
	.ir_in,
	.valid_in,
	.reg_data,
	.dest_reg,
	.cc_data,
	.ex_tag,
	.mem_tag,
	.wb_tag,
	.stall_in,
	.npc,
	.ir,
	.cw,
	.sr1,
	.sr2,
	.cc_out,
	.dr,
	.valid,
	.load_ex,
	.dep_stall,
	.decode_br_stall
);

initial
begin
	clk = 1'b0;
	forever
		#20 clk = ~clk;
end

task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("*** FAILED ***");
	$fatal(1);
endtask

task automatic wait_edge(input logic level);
	int steps;
	steps = 0;
	while (clk === level)
	begin
		#1;
		steps++;
		if (steps > edge_timeout)
			fail_run("Clock stuck, timed out before the edge");
	end
	while (clk !== level)
	begin
		#1;
		steps++;
		if (steps > edge_timeout)
			fail_run("Clock stuck, timed out waiting for an edge");
	end
endtask

// ~~~~~~~~~~~~~~~~~~~~
// Reference model
// ~~~~~~~~~~~~~~~~~~~~

task automatic update_model;
	if (rst)
	begin
		for (int i = 0; i < reg_count; i++)
			model_regs[i] = '0;
		model_cc = cc_reset;
	end
	else
	begin
		if (wb_tag.ld_reg)
			model_regs[dest_reg] = reg_data;
		if (wb_tag.ld_cc)
			model_cc = cc_data;
	end
endtask

task automatic next_cycle;
	wait_edge(1'b1);
	update_model();
	wait_edge(1'b0);                         // Inputs change on the falling edge
endtask

function automatic lc3b_control_word expected_cw(input lc3b_word instr);
	lc3b_control_word want;
	lc3b_opcode op;
	op = lc3b_opcode'(instr[15:12]);
	want = '0;
	want.opcode = op;
	case (op)
		op_add, op_and:
		begin
			want.sr1_needed = 1'b1;
			want.sr2_needed = !instr[5];
			want.regfilemux_sel = !instr[5];
			want.load_regfile = 1'b1;
			want.load_cc = 1'b1;
		end
		op_not, op_shf, op_ldb, op_ldr, op_ldi:
		begin
			want.sr1_needed = 1'b1;
			want.load_regfile = 1'b1;
			want.load_cc = 1'b1;
		end
		op_stb, op_str, op_sti:
		begin
			want.sr1_needed = 1'b1;
			want.sr2_needed = 1'b1;
		end
		op_lea:
		begin
			want.load_regfile = 1'b1;
			want.load_cc = 1'b1;
		end
		op_jsr, op_trap:
		begin
			want.sr1_needed = (op == op_jsr) && !instr[11];
			want.destmux_sel = 1'b1;
			want.load_regfile = 1'b1;
			want.is_branch = 1'b1;
		end
		op_jmp:
		begin
			want.sr1_needed = 1'b1;
			want.is_branch = 1'b1;
		end
		op_br:
			want.is_branch = 1'b1;
		default:
			want.is_branch = 1'b0;               // RTI does nothing here
	endcase
	return want;
endfunction

function automatic logic reg_hazard(input lc3b_reg id);
	return (ex_tag.ld_reg && ex_tag.drid == id) ||
		(mem_tag.ld_reg && mem_tag.drid == id) ||
		(wb_tag.ld_reg && wb_tag.drid == id);
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// Stimulus
// ~~~~~~~~~~~~~~~~~~~~

function automatic lc3b_wr_tag random_tag;
	lc3b_wr_tag tag;
	tag.drid = 3'($urandom_range(0, 7));
	tag.ld_reg = ($urandom_range(0, 2) == 0);
	tag.ld_cc = ($urandom_range(0, 3) == 0);
	return tag;
endfunction

task automatic clear_inputs;
	npc_in = '0;
	ir_in = '0;
	valid_in = 1'b0;
	reg_data = '0;
	dest_reg = '0;
	cc_data = '0;
	ex_tag = '0;
	mem_tag = '0;
	wb_tag = '0;
	stall_in = '0;
endtask

task automatic drive_random;
	npc_in = 16'($urandom);
	ir_in = 16'($urandom);
	valid_in = ($urandom_range(0, 7) != 0);
	reg_data = 16'($urandom);
	cc_data = lc3b_nzp'(3'b001 << $urandom_range(0, 3));   // One flag or none
	ex_tag = random_tag();
	mem_tag = random_tag();
	wb_tag = random_tag();
	dest_reg = wb_tag.drid;
	stall_in.execute_br_stall = ($urandom_range(0, 7) == 0);
	stall_in.execute_indirect_stall = ($urandom_range(0, 7) == 0);
	stall_in.mem_stall = ($urandom_range(0, 7) == 0);
	stall_in.mem_br_stall = ($urandom_range(0, 7) == 0);
	stall_in.icache_stall_int = ($urandom_range(0, 7) == 0);
endtask

// Register-mode ADD reading idx and 7 - idx
task automatic drive_reset_read(input int idx);
	clear_inputs();
	npc_in = 16'(idx);
	ir_in = {4'b0001, 3'(idx), 3'(idx), 3'b000, 3'(7 - idx)};
	valid_in = 1'b1;
endtask

task automatic check_outputs;
	lc3b_control_word want;
	lc3b_control_word got_cw;
	lc3b_reg want_sr2_id;
	lc3b_reg want_dr;
	logic want_dep;
	logic want_valid;
	logic want_load_ex;
	want = expected_cw(ir_in);
	got_cw = cw;
	got_cw.aluop = alu_add;                  // Fields outside the table
	got_cw.mem_read = 1'b0;
	got_cw.mem_write = 1'b0;
	got_cw.imm_mode = 1'b0;
	want_sr2_id = want.regfilemux_sel ? ir_in[2:0] : ir_in[11:9];
	want_dr = want.destmux_sel ? 3'd7 : ir_in[11:9];
	want_dep = valid_in && ((want.sr1_needed && reg_hazard(ir_in[8:6])) ||
		(want.sr2_needed && reg_hazard(want_sr2_id)) ||
		(want.opcode == op_br && (ex_tag.ld_cc || mem_tag.ld_cc || wb_tag.ld_cc)));
	want_valid = valid_in && !want_dep &&
		!stall_in.execute_br_stall && !stall_in.mem_br_stall;
	want_load_ex = !(stall_in.mem_stall || stall_in.execute_indirect_stall ||
		stall_in.icache_stall_int);

	assert (got_cw == want)
		else fail_run($sformatf("ERROR %0t: cw expected %h, got %h", $time, want, got_cw));
	assert (dr == want_dr)
		else fail_run($sformatf("ERROR %0t: dr expected %0d, got %0d", $time, want_dr, dr));
	assert (sr1 == model_regs[ir_in[8:6]])
		else fail_run($sformatf("ERROR %0t: sr1 expected %h, got %h",
			$time, model_regs[ir_in[8:6]], sr1));
	assert (sr2 == model_regs[want_sr2_id])
		else fail_run($sformatf("ERROR %0t: sr2 expected %h, got %h",
			$time, model_regs[want_sr2_id], sr2));
	assert (cc_out == model_cc)
		else fail_run($sformatf("ERROR %0t: cc_out expected %b, got %b",
			$time, model_cc, cc_out));
	assert (dep_stall == want_dep)
		else fail_run($sformatf("ERROR %0t: dep_stall expected %b, got %b",
			$time, want_dep, dep_stall));
	assert (valid == want_valid)
		else fail_run($sformatf("ERROR %0t: valid expected %b, got %b",
			$time, want_valid, valid));
	assert (decode_br_stall == (want_valid && want.is_branch))
		else fail_run($sformatf("ERROR %0t: decode_br_stall expected %b, got %b",
			$time, want_valid && want.is_branch, decode_br_stall));
	assert (load_ex == want_load_ex)
		else fail_run($sformatf("ERROR %0t: load_ex expected %b, got %b",
			$time, want_load_ex, load_ex));
	assert (npc == npc_in && ir == ir_in)
		else fail_run($sformatf("ERROR %0t: npc/ir expected %h/%h, got %h/%h",
			$time, npc_in, ir_in, npc, ir));
endtask

// ~~~~~~~~~~~~~~~~~~~~
// Test sequence
// ~~~~~~~~~~~~~~~~~~~~

initial
begin
	void'($urandom(32'h3caa));
	rst = 1'b1;
	clear_inputs();
	repeat (16)
	begin
		next_cycle();
		drive_random();                      // Writes under reset must not land
	end
	rst = 1'b0;

	for (int i = 0; i < reg_count; i++)      // Fresh registers read zero
	begin
		drive_reset_read(i);
		#5;
		check_outputs();
		next_cycle();
	end

	for (int n = 0; n < random_cycles; n++)
	begin
		drive_random();
		#5;
		check_outputs();
		next_cycle();
	end

	$display("*** PASSED ***");
	$finish;
end

endmodule : tb_decode_stage

/* filelist.f */
src/lc3b_types.sv
src/lc3b_ctrl_pkg.sv
src/control_rom.sv
src/operand_fetch.sv
src/hazard_unit.sv
src/decode_stage.sv
testbench/tb_decode_stage.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_decode_stage -f filelist.f \
	-o sim_decode_stage > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_decode_stage > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
